/* run.sh */
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_branch_predict -f src.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "ERRORS FOUND" "$LOG"; then
	exit 1
fi
exit 0

/* src.f */
verilog/bp_pkg.sv
verilog/branch_target_buffer.sv
verilog/direction_predictor.sv
verilog/fetch_pc_gen.sv
verilog/fetch_queue.sv
verilog/branch_resolve.sv
verilog/branch_predict_top.sv
testbench/tb_branch_predict.sv

/* testbench/tb_branch_predict.sv */
`timescale 1ns/1ps

module tb_branch_predict import bp_pkg::*; ();

	localparam logic [XLEN-1:0] RESET_PC = 64'h1000;
	localparam int FQ_DEPTH = 4;
	localparam int NUM_RES  = 400;	// Resolutions in the whole run.
	localparam int BP_START = 150;	// Stalls start here.
	localparam int LIMIT_NS = NUM_RES * 4 * 4 + NUM_RES * 8 + 400;	// Four cycles each, plus margin.

	logic clk, rst, ex_valid_i, ex_taken_i, head_valid_o;
	br_kind_e ex_kind_i;
	logic [XLEN-1:0] ex_target_i, head_pc_o, head_pred_next_o;

	br_kind_e prog_kind [64];	// Program model, one slot per word of the region.
	int prog_bias [64];
	logic [XLEN-1:0] prog_target [64];
	bit visited [64];

	logic m_valid [16];	// Model target buffer.
	logic [9:0] m_tag [16];
	logic [15:0] m_val [16];
	br_kind_e m_kind [16];
	logic [1:0] m_ctr [32];	// Model counters.

	bit u_valid, u_taken, r_valid, nu_valid, nu_taken, nr_valid;	// Update and redirect in flight.
	br_kind_e u_kind, nu_kind;
	logic [XLEN-1:0] u_pc, u_target, r_pc, nu_pc, nu_target, nr_pc;
	logic [XLEN-1:0] q_pc [$];	// Model of the fetch queue.
	logic [XLEN-1:0] q_pred [$];
	logic [XLEN-1:0] fetch_pc, last_actual, pred;
	bit push, flushing, answer_next, seen_taken, plan_taken;
	br_kind_e plan_kind;
	logic [XLEN-1:0] plan_target;
	int stall_left, res_count, redirects, errors, test_err;

	branch_predict_top #(.BTB_SEL_W(4), .BTB_TAG_W(10), .BTB_VAL_W(16), .DIRP_SEL_W(5),
		.FQ_DEPTH(FQ_DEPTH), .RESET_PC(RESET_PC)) uut (.*);

	function automatic logic [1:0] step_ctr(input logic [1:0] c, input bit t);
		if (t) return (c == 2'd3) ? c : c + 2'd1;	// Saturate at strong taken.
		return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	// Expected predicted next PC from the model tables and the update of this cycle.
	function automatic logic [XLEN-1:0] predict_next(input logic [XLEN-1:0] pc);
		logic [3:0] bi;
		logic [4:0] di;
		bit hit;
		br_kind_e kind;
		logic [XLEN-1:0] tgt;
		logic [1:0] ctr;
		bi = pc[5:2];
		di = pc[6:2];
		hit = m_valid[bi] && (m_tag[bi] == pc[15:6]);
		kind = m_kind[bi];
		tgt = {pc[XLEN-1:18], m_val[bi], 2'b00};
		ctr = m_ctr[di];
		if (u_valid && pc == u_pc) begin	// Write cycle forward.
			hit = u_taken;
			kind = u_kind;
			tgt = u_target;
			if (u_kind == BR_COND) ctr = step_ctr(m_ctr[di], u_taken);
		end
		if (hit && (kind == BR_UNCOND || ctr[1])) return tgt;
		return pc + 64'd4;
	endfunction

	task automatic apply_update();
		if (u_valid) begin
			m_valid[u_pc[5:2]] = u_taken;	// Not taken clears.
			if (u_taken) begin
				m_tag[u_pc[5:2]] = u_pc[15:6];
				m_val[u_pc[5:2]] = u_target[17:2];
				m_kind[u_pc[5:2]] = u_kind;
			end
			if (u_kind == BR_COND) m_ctr[u_pc[6:2]] = step_ctr(m_ctr[u_pc[6:2]], u_taken);
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s: %s, %0d errors", name, (errors == test_err) ? "pass" : "fail",
			errors - test_err);
		test_err = errors;
	endtask

	// Checks the popped head and books its outcome.
	task automatic resolve_head();
		logic [XLEN-1:0] pc, exp_pred, actual;
		pc = q_pc.pop_front();
		exp_pred = q_pred.pop_front();
		actual = ex_taken_i ? ex_target_i : pc + 64'd4;
		assert (head_pc_o === last_actual && pc === last_actual) else begin
			$display("mismatch head_pc_o: got %h expected %h", head_pc_o, last_actual);
			errors++;
		end
		assert (head_pred_next_o === exp_pred) else begin
			$display("mismatch head_pred_next_o: got %h expected %h", head_pred_next_o, exp_pred);
			errors++;
		end
		assert (seen_taken || head_pred_next_o === pc + 64'd4) else begin
			$display("prediction other than PC plus 4 before any taken branch at %h", pc);
			errors++;
		end
		if (ex_kind_i == BR_UNCOND && !visited[pc[7:2]] && ex_target_i != pc + 64'd4)
			assert (actual != head_pred_next_o) else begin
				$display("unconditional branch at %h predicted on its first visit", pc);
				errors++;
			end
		visited[pc[7:2]] = 1'b1;
		nu_valid = (ex_kind_i != BR_NONE);
		nu_pc = pc;
		nu_kind = ex_kind_i;
		nu_taken = ex_taken_i;
		nu_target = ex_target_i;
		nr_valid = (actual != exp_pred);	// Misprediction redirects next cycle.
		nr_pc = actual;
		redirects += int'(nr_valid);
		last_actual = actual;
		res_count++;
		if (ex_taken_i && !seen_taken) report_test("reset");
		seen_taken |= ex_taken_i;
		if (res_count == BP_START) report_test("correct path");
		if (res_count == NUM_RES) report_test("back-pressure");
	endtask

	always @(negedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				m_ctr[i] = 2'b01;	// Weakly not taken.
				if (i < 16) m_valid[i] = 1'b0;
			end
			u_valid = 0;
			r_valid = 0;
			q_pc.delete();
			q_pred.delete();
			fetch_pc = RESET_PC;
			last_actual = RESET_PC;
		end else begin
			assert (head_valid_o === (q_pc.size() != 0)) else begin
				$display("mismatch head_valid_o: got %h expected %h", head_valid_o,
					q_pc.size() != 0);
				errors++;
			end
			flushing = r_valid;
			push = !r_valid && (q_pc.size() < FQ_DEPTH);	// Full is seen before the pop.
			nu_valid = 0;
			nr_valid = 0;
			if (ex_valid_i) resolve_head();
			if (flushing) begin
				fetch_pc = r_pc;
				q_pc.delete();
				q_pred.delete();
			end else if (push) begin
				pred = predict_next(fetch_pc);
				q_pc.push_back(fetch_pc);
				q_pred.push_back(pred);
				fetch_pc = pred;
			end
			apply_update();
			u_valid = nu_valid;
			u_pc = nu_pc;
			u_kind = nu_kind;
			u_taken = nu_taken;
			u_target = nu_target;
			r_valid = nr_valid;
			r_pc = nr_pc;
			answer_next = !ex_valid_i && !flushing && (q_pc.size() > 0) && (res_count < NUM_RES);
			if (res_count >= BP_START && answer_next) begin
				if (stall_left > 0) begin
					stall_left--;
					answer_next = 0;
				end else if ($urandom % 4 == 0) begin
					stall_left = 1 + $urandom % 8;	// Random stretch, queue fills.
					answer_next = 0;
				end
			end
			if (answer_next) begin
				plan_kind = prog_kind[q_pc[0][7:2]];
				plan_taken = (plan_kind == BR_UNCOND) ||
					(plan_kind == BR_COND && ($urandom % 4) < prog_bias[q_pc[0][7:2]]);
				plan_target = prog_target[q_pc[0][7:2]];
			end
		end
	end

	always @(posedge clk) begin
		ex_valid_i <= answer_next;
		ex_kind_i <= plan_kind;
		ex_taken_i <= plan_taken;
		ex_target_i <= plan_target;
	end

	initial begin
		clk = 0;
		forever #2 clk = ~clk;
	end

	initial begin
		#LIMIT_NS;
		$display("timeout after %0d resolutions", res_count);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		void'($urandom(32'h33ce_72e7));
		rst = 1;
		{ex_valid_i, ex_taken_i, ex_target_i, answer_next, plan_taken, plan_target} = '0;
		ex_kind_i = BR_NONE;
		plan_kind = BR_NONE;
		{stall_left, res_count, redirects, errors, test_err, seen_taken} = '0;
		for (int i = 0; i < 64; i++) begin
			prog_kind[i] = ($urandom % 8 < 3) ? BR_NONE : ($urandom % 3 == 0) ? BR_UNCOND : BR_COND;
			prog_bias[i] = $urandom % 5;	// Out of four, so four is always taken.
			prog_target[i] = RESET_PC + XLEN'(($urandom % 64) * 4);
			visited[i] = 0;
		end
		prog_kind[63] = BR_UNCOND;	// Last word loops back to the region start.
		prog_target[63] = RESET_PC;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		wait (res_count == NUM_RES);
		repeat (2) @(posedge clk);
		$display("resolutions %0d, redirects %0d, errors %0d", res_count, redirects, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* verilog/bp_pkg.sv */
package bp_pkg;

	// Address width of the fetch unit.
	localparam int XLEN = 64;

	// Branch kind as seen by the target buffer and the resolve stage.
	typedef enum logic [1:0] {
		BR_NONE   = 2'b00,	// Not a branch, falls through.
		BR_COND   = 2'b01,	// Conditional, direction from the counters.
		BR_UNCOND = 2'b10	// Always taken.
	} br_kind_e;

	// Two-bit saturating counter.
	// The upper bit gives the predicted direction.
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,	// Strongly not taken.
		WEAK_NT   = 2'b01,	// Weakly not taken, the reset state.
		WEAK_T    = 2'b10,	// Weakly taken.
		STRONG_T  = 2'b11	// Strongly taken.
	} ctr_state_e;

endpackage

/* verilog/branch_predict_top.sv */
`timescale 1ns/1ps

module branch_predict_top import bp_pkg::*; #(
	parameter int              BTB_SEL_W  = 4,
	parameter int              BTB_TAG_W  = 10,
	parameter int              BTB_VAL_W  = 16,
	parameter int              DIRP_SEL_W = 5,
	parameter int              FQ_DEPTH   = 4,
	parameter logic [XLEN-1:0] RESET_PC   = 32'h1000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            ex_valid_i,
	input  br_kind_e        ex_kind_i,
	input  logic            ex_taken_i,
	input  logic [XLEN-1:0] ex_target_i,
	output logic            head_valid_o,
	output logic [XLEN-1:0] head_pc_o,
	output logic [XLEN-1:0] head_pred_next_o
);

	logic [XLEN-1:0] fetch_pc, pred_next, btb_target;
	logic            btb_hit, dirp_taken;
	br_kind_e        btb_kind;
	logic            fq_push, fq_full, fq_pop;
	logic            upd_valid, upd_taken;
	logic [XLEN-1:0] upd_pc, upd_target;
	br_kind_e        upd_kind;
	logic            redirect;
	logic [XLEN-1:0] redirect_pc;

	branch_target_buffer #(.BTB_SEL_W(BTB_SEL_W), .BTB_TAG_W(BTB_TAG_W), .BTB_VAL_W(BTB_VAL_W)) u_btb (
		.clk, .rst, .fetch_pc_i(fetch_pc), .upd_valid_i(upd_valid), .upd_pc_i(upd_pc),
		.upd_kind_i(upd_kind), .upd_taken_i(upd_taken), .upd_target_i(upd_target),
		.hit_o(btb_hit), .kind_o(btb_kind), .target_o(btb_target));

	direction_predictor #(.DIRP_SEL_W(DIRP_SEL_W)) u_dirp (
		.clk, .rst, .fetch_pc_i(fetch_pc), .upd_valid_i(upd_valid), .upd_pc_i(upd_pc),
		.upd_kind_i(upd_kind), .upd_taken_i(upd_taken), .taken_o(dirp_taken));

	fetch_pc_gen #(.RESET_PC(RESET_PC)) u_pc_gen (
		.clk, .rst, .btb_hit_i(btb_hit), .btb_kind_i(btb_kind), .btb_target_i(btb_target),
		.dirp_taken_i(dirp_taken), .fq_full_i(fq_full), .redirect_i(redirect),
		.redirect_pc_i(redirect_pc), .fetch_pc_o(fetch_pc), .pred_next_o(pred_next),
		.push_o(fq_push));

	fetch_queue #(.FQ_DEPTH(FQ_DEPTH)) u_fq (
		.clk, .rst, .push_i(fq_push), .push_pc_i(fetch_pc), .push_pred_next_i(pred_next),
		.pop_i(fq_pop), .flush_i(redirect), .full_o(fq_full), .head_valid_o,
		.head_pc_o, .head_pred_next_o);

	branch_resolve u_resolve (
		.clk, .rst, .head_valid_i(head_valid_o), .head_pc_i(head_pc_o),
		.head_pred_next_i(head_pred_next_o), .ex_valid_i, .ex_kind_i, .ex_taken_i,
		.ex_target_i, .pop_o(fq_pop), .upd_valid_o(upd_valid), .upd_pc_o(upd_pc),
		.upd_kind_o(upd_kind), .upd_taken_o(upd_taken), .upd_target_o(upd_target),
		.redirect_o(redirect), .redirect_pc_o(redirect_pc));

endmodule

/* verilog/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve import bp_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            head_valid_i,	// Queue head present.
	input  logic [XLEN-1:0] head_pc_i,
	input  logic [XLEN-1:0] head_pred_next_i,
	input  logic            ex_valid_i,	// Execute outcome for the head.
	input  br_kind_e        ex_kind_i,
	input  logic            ex_taken_i,
	input  logic [XLEN-1:0] ex_target_i,
	output logic            pop_o,
	output logic            upd_valid_o,	// One-cycle training strobe.
	output logic [XLEN-1:0] upd_pc_o,
	output br_kind_e        upd_kind_o,
	output logic            upd_taken_o,
	output logic [XLEN-1:0] upd_target_o,
	output logic            redirect_o,	// Flush and reload fetch.
	output logic [XLEN-1:0] redirect_pc_o
);

	logic [XLEN-1:0] actual_next;
	logic            mispredict;

	// Head in the redirect cycle is wrong-path and is dropped by the flush.
	assign pop_o = ex_valid_i && head_valid_i && !redirect_o;

	assign actual_next = ex_taken_i ? ex_target_i : head_pc_i + XLEN'(4);
	assign mispredict  = (actual_next != head_pred_next_i);	// Also catches stale BR_NONE hits.

	always_ff @(posedge clk) begin
		if (rst) begin
			upd_valid_o <= 1'b0;
			redirect_o  <= 1'b0;
		end else begin
			upd_valid_o <= pop_o && (ex_kind_i != BR_NONE);
			redirect_o  <= pop_o && mispredict;
		end
	end

	always_ff @(posedge clk) begin
		if (pop_o) begin
			upd_pc_o      <= head_pc_i;
			upd_kind_o    <= ex_kind_i;
			upd_taken_o   <= ex_taken_i;
			upd_target_o  <= ex_target_i;
			redirect_pc_o <= actual_next;
		end
	end

	// Execute side answers only for a live head.
	assert property (@(posedge clk) disable iff (rst) ex_valid_i |-> head_valid_i)
		else $error("branch_resolve: ex_valid_i without a queue head");

endmodule

/* verilog/branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer import bp_pkg::*; #(
	parameter int BTB_SEL_W = 4,
	parameter int BTB_TAG_W = 10,
	parameter int BTB_VAL_W = 16
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [XLEN-1:0]  fetch_pc_i,	// PC looked up in the fetch cycle.
	input  logic             upd_valid_i,	// One-cycle strobe from the resolve stage.
	input  logic [XLEN-1:0]  upd_pc_i,	// PC of the resolved branch.
	input  br_kind_e         upd_kind_i,	// Kind of the resolved branch.
	input  logic             upd_taken_i,	// Taken installs, not taken clears.
	input  logic [XLEN-1:0]  upd_target_i,	// Resolved target.
	output logic             hit_o,		// PC holds a known taken branch.
	output br_kind_e         kind_o,		// Stored kind on a hit.
	output logic [XLEN-1:0]  target_o	// Predicted target on a hit.
);

	localparam int NUM = 1 << BTB_SEL_W;

	logic [BTB_TAG_W-1:0] tags [NUM];	// Tag per entry.
	logic [BTB_VAL_W-1:0] vals [NUM];	// Low target bits, word aligned.
	br_kind_e             kinds [NUM];
	logic [NUM-1:0]       valid;		// Entry holds a live branch.

	logic [BTB_SEL_W-1:0] fetch_sel, upd_sel;
	logic [BTB_TAG_W-1:0] fetch_tag, upd_tag;
	logic                 table_hit;
	logic                 bypass;

	// Index sits right above the word offset, tag right above the index.
	assign fetch_sel = fetch_pc_i[BTB_SEL_W+1:2];
	assign fetch_tag = fetch_pc_i[BTB_TAG_W+BTB_SEL_W+1:BTB_SEL_W+2];
	assign upd_sel   = upd_pc_i[BTB_SEL_W+1:2];
	assign upd_tag   = upd_pc_i[BTB_TAG_W+BTB_SEL_W+1:BTB_SEL_W+2];

	assign table_hit = valid[fetch_sel] && (tags[fetch_sel] == fetch_tag);
	assign bypass    = upd_valid_i && (fetch_pc_i == upd_pc_i);	// Write cycle forward.

	always_comb begin
		if (bypass) begin
			hit_o    = upd_taken_i;
			kind_o   = upd_taken_i ? upd_kind_i : BR_NONE;
			target_o = upd_taken_i ? upd_target_i : '0;
		end else if (table_hit) begin
			hit_o    = 1'b1;
			kind_o   = kinds[fetch_sel];
			// Upper bits come from the fetch PC.
			target_o = {fetch_pc_i[XLEN-1:BTB_VAL_W+2], vals[fetch_sel], 2'b00};
		end else begin
			hit_o    = 1'b0;
			kind_o   = BR_NONE;
			target_o = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;	// All entries start empty.
		end else if (upd_valid_i) begin
			valid[upd_sel] <= upd_taken_i;	// Not taken clears the entry.
		end
	end

	always_ff @(posedge clk) begin
		if (upd_valid_i && upd_taken_i) begin
			tags[upd_sel]  <= upd_tag;
			vals[upd_sel]  <= upd_target_i[BTB_VAL_W+1:2];
			kinds[upd_sel] <= upd_kind_i;
		end
	end

	// Resolve only strobes for real branches.
	assert property (@(posedge clk) disable iff (rst) upd_valid_i |-> upd_kind_i != BR_NONE)
		else $error("btb: update strobe with BR_NONE");

endmodule

/* verilog/direction_predictor.sv */
`timescale 1ns/1ps

module direction_predictor import bp_pkg::*; #(
	parameter int DIRP_SEL_W = 5
) (
	input  logic            clk,
	input  logic            rst,
	input  logic [XLEN-1:0] fetch_pc_i,	// PC looked up in the fetch cycle.
	input  logic            upd_valid_i,	// Resolve strobe.
	input  logic [XLEN-1:0] upd_pc_i,
	input  br_kind_e        upd_kind_i,	// Only BR_COND trains.
	input  logic            upd_taken_i,
	output logic            taken_o		// Upper bit of the counter.
);

	localparam int NUM = 1 << DIRP_SEL_W;

	ctr_state_e             ctrs [NUM];
	logic [DIRP_SEL_W-1:0]  fetch_sel, upd_sel;
	logic                   train;
	ctr_state_e             ctr_next;	// Trained value of the updated counter.

	assign fetch_sel = fetch_pc_i[DIRP_SEL_W+1:2];
	assign upd_sel   = upd_pc_i[DIRP_SEL_W+1:2];
	assign train     = upd_valid_i && (upd_kind_i == BR_COND);

	// One step toward the outcome, saturating at both ends.
	always_comb begin
		case (ctrs[upd_sel])
			STRONG_NT: ctr_next = upd_taken_i ? WEAK_NT : STRONG_NT;
			WEAK_NT:   ctr_next = upd_taken_i ? WEAK_T : STRONG_NT;
			WEAK_T:    ctr_next = upd_taken_i ? STRONG_T : WEAK_NT;
			default:   ctr_next = upd_taken_i ? STRONG_T : WEAK_T;
		endcase
	end

	// Same-cycle bypass, as in the target buffer.
	assign taken_o = (train && (fetch_pc_i == upd_pc_i)) ? ctr_next[1] : ctrs[fetch_sel][1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM; i++) begin
				ctrs[i] <= WEAK_NT;	// Weak bias toward fall-through.
			end
		end else if (train) begin
			ctrs[upd_sel] <= ctr_next;
		end
	end

endmodule

/* verilog/fetch_pc_gen.sv */
`timescale 1ns/1ps

module fetch_pc_gen import bp_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h1000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            btb_hit_i,	// Target buffer hit for fetch_pc_o.
	input  br_kind_e        btb_kind_i,
	input  logic [XLEN-1:0] btb_target_i,
	input  logic            dirp_taken_i,	// Counter direction for fetch_pc_o.
	input  logic            fq_full_i,	// Queue back-pressure.
	input  logic            redirect_i,	// Misprediction from resolve.
	input  logic [XLEN-1:0] redirect_pc_i,
	output logic [XLEN-1:0] fetch_pc_o,	// Current fetch PC.
	output logic [XLEN-1:0] pred_next_o,	// Predicted next PC, pushed with fetch_pc_o.
	output logic            push_o
);

	logic pred_taken;

	// Unconditional hits are always taken, conditional ones ask the counter.
	assign pred_taken  = btb_hit_i && ((btb_kind_i == BR_UNCOND) || dirp_taken_i);
	assign pred_next_o = pred_taken ? btb_target_i : fetch_pc_o + XLEN'(4);

	// A redirect kills the push of a wrong-path PC.
	assign push_o = !fq_full_i && !redirect_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc_o <= RESET_PC;
		end else if (redirect_i) begin
			fetch_pc_o <= redirect_pc_i;	// Redirect beats a push.
		end else if (push_o) begin
			fetch_pc_o <= pred_next_o;
		end
		// Otherwise hold under back-pressure.
	end

endmodule

/* verilog/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue import bp_pkg::*; #(
	parameter int FQ_DEPTH = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            push_i,
	input  logic [XLEN-1:0] push_pc_i,
	input  logic [XLEN-1:0] push_pred_next_i,
	input  logic            pop_i,
	input  logic            flush_i,	// Drops every entry.
	output logic            full_o,
	output logic            head_valid_o,
	output logic [XLEN-1:0] head_pc_o,
	output logic [XLEN-1:0] head_pred_next_o
);

	localparam int PTR_W = (FQ_DEPTH > 1) ? $clog2(FQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(FQ_DEPTH + 1);

	logic [XLEN-1:0]  pc_mem [FQ_DEPTH];
	logic [XLEN-1:0]  pred_mem [FQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;

	assign full_o           = (count == CNT_W'(FQ_DEPTH));
	assign head_valid_o     = (count != '0);
	assign head_pc_o        = pc_mem[rd_ptr];
	assign head_pred_next_o = pred_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= (wr_ptr == PTR_W'(FQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;	// Wrap.
			end
			if (pop_i) begin
				rd_ptr <= (rd_ptr == PTR_W'(FQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push_i) - CNT_W'(pop_i);
		end
	end

	always_ff @(posedge clk) begin
		if (push_i) begin
			pc_mem[wr_ptr]   <= push_pc_i;
			pred_mem[wr_ptr] <= push_pred_next_i;
		end
	end

	assert property (@(posedge clk) disable iff (rst) push_i |-> !full_o)
		else $error("fetch_queue: push while full");
	assert property (@(posedge clk) disable iff (rst) pop_i |-> head_valid_o)
		else $error("fetch_queue: pop while empty");

endmodule
